//--- common/spi_reg_pkg.sv
// SPI register bridge shared sizes, command layout and bus structs
`default_nettype none

package spi_reg_pkg;

    // ==========================================================
    // Register bank geometry
    // ==========================================================

    // Number of byte-wide control registers
    localparam int REG_COUNT = 16;

    // Index width into the bank
    localparam int REG_ADDR_W = $clog2(REG_COUNT);

    // ==========================================================
    // Command byte layout
    // ==========================================================

    // Bit 7 of the command byte, set for write
    localparam int CMD_WR_BIT = 7;

    // Start address in bits 6:0
    localparam int CMD_ADDR_W = 7;

    // Returned on MISO while the command byte is in flight
    localparam logic [7:0] DEVICE_ID = 8'hA5;

    // ==========================================================
    // Bus structs
    // ==========================================================

    // One received SPI byte
    typedef struct packed {
        logic [7:0] data;
        logic       first;   // first byte after select
    } spi_rx_t;

    // One register write from the decoder
    typedef struct packed {
        logic [CMD_ADDR_W-1:0] addr;
        logic [7:0]            data;
    } reg_wr_t;

    // All register contents, element i is register i
    typedef logic [REG_COUNT-1:0][7:0] reg_file_t;

endpackage

`default_nettype wire

//--- spi_slave/spi_pin_sync.sv
// Two-flop synchronizer bringing asynchronous SPI pin levels into clk
`timescale 1ns/1ps
`default_nettype none

module spi_pin_sync #(
    parameter int WIDTH = 3
) (
    input  logic             clk,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    // First stage, may go metastable
    logic [WIDTH-1:0] meta_q;

    // Two stages per bit
    always_ff @(posedge clk) begin
        meta_q <= din;
        dout   <= meta_q;
    end

endmodule

`default_nettype wire

//--- spi_slave/spi_slave_if.sv
// Byte-level SPI slave for mode CPOL 0 CPHA 1 with SCK edge detect and shifters
`timescale 1ns/1ps
`default_nettype none

// ==========================================================
// MISO changes on rising SCK and MOSI is sampled on falling SCK
// SCK is oversampled in the clk domain and the master must
// hold each half period for at least eight clk cycles
// ==========================================================

module spi_slave_if (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sck,
    input  logic                 ss_n,
    input  logic                 mosi,
    output logic                 miso,
    output logic                 miso_oe,
    output logic                 sel,
    output spi_reg_pkg::spi_rx_t rx,
    output logic                 rx_valid,
    input  logic [7:0]           tx_data,
    output logic                 tx_load
);

    // Synchronized pin levels
    logic       sck_s;
    logic       ss_n_s;
    logic       mosi_s;

    // Edge detect
    logic       sck_d;
    logic       fall_edge;
    logic       rise_edge;

    // Receive side
    logic [2:0] rx_bit_cnt;
    logic [6:0] rx_shift;
    logic       cmd_done;

    // Transmit side
    logic [2:0] tx_bit_cnt;
    logic [6:0] tx_shift;

    spi_pin_sync #(
        .WIDTH(3)
    ) pin_sync0 (
        .clk (clk),
        .din ({sck, ss_n, mosi}),
        .dout({sck_s, ss_n_s, mosi_s})
    );

    // Pin driven straight from the raw select
    assign miso_oe = ~ss_n;

    // Active-high select in clk domain
    assign sel = ~ss_n_s;

    // ==========================================================
    // SCK edge detection
    // ==========================================================

    // SCK idles low in CPOL 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck_d <= 1'b0;
        end else begin
            sck_d <= sck_s;
        end
    end

    assign fall_edge = sck_d & ~sck_s;
    assign rise_edge = ~sck_d & sck_s;

    // ==========================================================
    // Receive path
    // ==========================================================

    // Bit counter cleared on deselect so an aborted byte is lost
    always_ff @(posedge clk) begin
        if (!rst_n || !sel) begin
            rx_bit_cnt <= 3'd0;
        end else if (fall_edge) begin
            rx_bit_cnt <= rx_bit_cnt + 3'd1;
        end
    end

    // MSB first with the newest bit at the bottom
    always_ff @(posedge clk) begin
        if (fall_edge) begin
            rx_shift <= {rx_shift[5:0], mosi_s};
        end
    end

    // Byte ends on the eighth falling edge
    assign rx_valid = fall_edge & sel & (rx_bit_cnt == 3'd7);

    // Set once the command byte has been received
    always_ff @(posedge clk) begin
        if (!rst_n || !sel) begin
            cmd_done <= 1'b0;
        end else if (rx_valid) begin
            cmd_done <= 1'b1;
        end
    end

    // Last bit bypasses the shifter
    assign rx.data  = {rx_shift, mosi_s};
    assign rx.first = ~cmd_done;

    // ==========================================================
    // Transmit path
    // ==========================================================

    always_ff @(posedge clk) begin
        if (!rst_n || !sel) begin
            tx_bit_cnt <= 3'd0;
        end else if (rise_edge) begin
            tx_bit_cnt <= tx_bit_cnt + 3'd1;
        end
    end

    // First rising edge of each byte
    assign tx_load = rise_edge & sel & (tx_bit_cnt == 3'd0);

    // Load new byte at bit 0 or shift toward MISO
    always_ff @(posedge clk) begin
        if (rise_edge) begin
            if (tx_load) begin
                {miso, tx_shift} <= tx_data;
            end else begin
                {miso, tx_shift} <= {tx_shift, 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/spi_cmd_decoder.sv
// SPI transaction parser with command latch, address pointer, writes and TX byte select
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_decoder (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               sel,
    input  spi_reg_pkg::spi_rx_t               rx,
    input  logic                               rx_valid,
    input  logic                               tx_load,
    output logic [7:0]                         tx_data,
    output spi_reg_pkg::reg_wr_t               wr,
    output logic                               wr_valid,
    output logic [spi_reg_pkg::CMD_ADDR_W-1:0] rd_addr,
    input  logic [7:0]                         rd_data
);

    import spi_reg_pkg::*;

    // Transaction state
    logic                  wr_cmd;
    logic                  id_sent;
    logic [CMD_ADDR_W-1:0] ptr;

    // Helpers
    logic                  data_byte;
    logic                  ptr_at_max;

    // Any byte after the command
    assign data_byte = rx_valid & ~rx.first;

    // Pointer stops at the top of the address field
    assign ptr_at_max = &ptr;

    // ==========================================================
    // Command latch and address pointer
    // ==========================================================

    // Deselect ends the transaction and the next byte is a command again
    always_ff @(posedge clk) begin
        if (!rst_n || !sel) begin
            wr_cmd  <= 1'b0;
            id_sent <= 1'b0;
            ptr     <= '0;
        end else begin
            // ID byte goes out with the first load
            if (tx_load) begin
                id_sent <= 1'b1;
            end
            if (rx_valid && rx.first) begin
                wr_cmd <= rx.data[CMD_WR_BIT];
                ptr    <= rx.data[CMD_ADDR_W-1:0];
            end else if (data_byte && !ptr_at_max) begin
                ptr <= ptr + CMD_ADDR_W'(1);
            end
        end
    end

    // ==========================================================
    // Register write
    // ==========================================================

    // One-cycle strobe after the data byte lands
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= data_byte & wr_cmd;
        end
    end

    // Address is the pointer before it steps
    always_ff @(posedge clk) begin
        if (data_byte) begin
            wr.addr <= ptr;
            wr.data <= rx.data;
        end
    end

    // ==========================================================
    // Transmit byte select
    // ==========================================================

    assign rd_addr = ptr;

    // Device ID during the command byte and register data after
    assign tx_data = id_sent ? rd_data : DEVICE_ID;

endmodule

`default_nettype wire

//--- hdl/spi_reg_bank.sv
// Bank of byte-wide control registers with write port and range-checked read mux
`timescale 1ns/1ps
`default_nettype none

module spi_reg_bank (
    input  logic                               clk,
    input  logic                               rst_n,
    input  spi_reg_pkg::reg_wr_t               wr,
    input  logic                               wr_valid,
    input  logic [spi_reg_pkg::CMD_ADDR_W-1:0] rd_addr,
    output logic [7:0]                         rd_data,
    output spi_reg_pkg::reg_file_t             regs
);

    import spi_reg_pkg::*;

    // Address inside the bank
    logic wr_hit;
    logic rd_hit;

    // ==========================================================
    // Write port
    // ==========================================================

    // Out of range writes are dropped
    assign wr_hit = wr_valid && (wr.addr < CMD_ADDR_W'(REG_COUNT));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '0;
        end else if (wr_hit) begin
            regs[wr.addr[REG_ADDR_W-1:0]] <= wr.data;
        end
    end

    // ==========================================================
    // Read mux
    // ==========================================================

    assign rd_hit = rd_addr < CMD_ADDR_W'(REG_COUNT);

    // Unmapped addresses read as zero
    always_comb begin
        if (rd_hit) begin
            rd_data = regs[rd_addr[REG_ADDR_W-1:0]];
        end else begin
            rd_data = 8'h00;
        end
    end

endmodule

`default_nettype wire

//--- hdl/spi_reg_top.sv
// SPI slave register bridge top joining slave port, decoder and register bank
`timescale 1ns/1ps
`default_nettype none

module spi_reg_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sck,
    input  logic                   ss_n,
    input  logic                   mosi,
    output logic                   miso,
    output logic                   miso_oe,
    output spi_reg_pkg::reg_file_t reg_q
);

    import spi_reg_pkg::*;

    // Slave port to decoder
    logic                  sel;
    spi_rx_t               rx;
    logic                  rx_valid;
    logic [7:0]            tx_data;
    logic                  tx_load;

    // Decoder to bank
    reg_wr_t               wr;
    logic                  wr_valid;
    logic [CMD_ADDR_W-1:0] rd_addr;
    logic [7:0]            rd_data;

    spi_slave_if slave_if0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .sck     (sck),
        .ss_n    (ss_n),
        .mosi    (mosi),
        .miso    (miso),
        .miso_oe (miso_oe),
        .sel     (sel),
        .rx      (rx),
        .rx_valid(rx_valid),
        .tx_data (tx_data),
        .tx_load (tx_load)
    );

    spi_cmd_decoder cmd_decoder0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .sel     (sel),
        .rx      (rx),
        .rx_valid(rx_valid),
        .tx_load (tx_load),
        .tx_data (tx_data),
        .wr      (wr),
        .wr_valid(wr_valid),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // Parallel register contents leave as reg_q
    spi_reg_bank reg_bank0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wr),
        .wr_valid(wr_valid),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .regs    (reg_q)
    );

endmodule

`default_nettype wire

//--- dv/spi_reg_tb.sv
// Self-checking testbench for the SPI register bridge with SPI master model and reference
`timescale 1ns/1ps
`default_nettype none

module spi_reg_tb;

    import spi_reg_pkg::*;

    // ==========================================================
    // Timing and table sizes
    // ==========================================================

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int HALF_CLKS    = 8;
    localparam int SETTLE_CLKS  = 20;
    localparam int TXN_N        = 40;
    localparam int TAIL_N       = 4;
    // Five bytes of 16 clk per bit worst case plus a fifth
    localparam int TIMEOUT_CYCLES = (TXN_N * 5 * 16 * 8) * 12 / 10 + RESET_CYCLES;

    // One table entry with data byte 0 sent first
    typedef struct packed {
        logic                  wr;
        logic [CMD_ADDR_W-1:0] addr;
        logic [2:0]            count;
        logic                  abort;   // last data byte cut after four bits
        logic [3:0][7:0]       data;
    } txn_t;

    logic      clk;
    logic      rst_n;
    logic      sck;
    logic      ss_n;
    logic      mosi;
    logic      miso;
    logic      miso_oe;
    reg_file_t reg_q;

    // Stimulus and expected values
    txn_t            txns [TXN_N];
    logic [3:0][7:0] exp_rd [TXN_N];
    reg_file_t       exp_regs [TXN_N];
    int              n_txn;

    int error_count;
    int check_count;
    int cycle_cnt;

    spi_reg_top dut0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .sck    (sck),
        .ss_n   (ss_n),
        .mosi   (mosi),
        .miso   (miso),
        .miso_oe(miso_oe),
        .reg_q  (reg_q)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout, test did not end within %0d clk cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // ==========================================================
    // Helpers
    // ==========================================================

    // Lands 1 ns after a rising edge
    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        assert (got === exp) else begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_regs(input string name, input reg_file_t got, input reg_file_t exp);
        check_count++;
        assert (got === exp) else begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic add_txn(input logic wr, input int addr, input int count,
                           input logic abort, input logic [31:0] data);
        txns[n_txn].wr    = wr;
        txns[n_txn].addr  = CMD_ADDR_W'(addr);
        txns[n_txn].count = 3'(count);
        txns[n_txn].abort = abort;
        txns[n_txn].data  = data;
        n_txn++;
    endtask

    // Reference register model walked over the whole table
    task automatic build_expected();
        reg_file_t model;
        int        n;
        int        i;
        int        a;
        int        nwr;
        model = '0;
        for (n = 0; n < TXN_N; n++) begin
            exp_rd[n] = '0;
            nwr = txns[n].abort ? int'(txns[n].count) - 1 : int'(txns[n].count);
            for (i = 0; i < int'(txns[n].count); i++) begin
                a = int'(txns[n].addr) + i;
                // Out of range writes are dropped and reads give 00
                if (txns[n].wr && i < nwr && a < REG_COUNT) begin
                    model[REG_ADDR_W'(a)] = txns[n].data[2'(i)];
                end
                if (!txns[n].wr && a < REG_COUNT) begin
                    exp_rd[n][2'(i)] = model[REG_ADDR_W'(a)];
                end
            end
            exp_regs[n] = model;
        end
    endtask

    // ==========================================================
    // SPI master, CPOL 0 CPHA 1, MSB first
    // ==========================================================

    // Fewer than 8 bits leaves SCK low mid-byte
    task automatic shift_byte(input logic [7:0] out_byte, input int nbits,
                              output logic [7:0] in_byte);
        int b;
        in_byte = 8'h00;
        for (b = 7; b >= 8 - nbits; b--) begin
            // MOSI moves mid low phase well after the last fall
            mosi = out_byte[3'(b)];
            wait_clks(HALF_CLKS / 2);
            sck = 1'b1;
            wait_clks(HALF_CLKS);
            in_byte[3'(b)] = miso;
            sck = 1'b0;
            wait_clks(HALF_CLKS / 2);
        end
    endtask

    task automatic run_txn(input int n);
        txn_t       t;
        logic [7:0] got;
        int         i;
        int         nbits;
        t = txns[n];
        ss_n = 1'b0;
        wait_clks(HALF_CLKS);
        check_bit("miso_oe", miso_oe, 1'b1);
        shift_byte({t.wr, t.addr}, 8, got);
        check_byte("miso id", got, DEVICE_ID);
        for (i = 0; i < int'(t.count); i++) begin
            nbits = (t.abort && i == int'(t.count) - 1) ? 4 : 8;
            shift_byte(t.data[2'(i)], nbits, got);
            if (!t.wr && nbits == 8) begin
                check_byte($sformatf("miso[%0d]", i), got, exp_rd[n][2'(i)]);
            end
        end
        wait_clks(HALF_CLKS);
        ss_n = 1'b1;
        mosi = 1'b0;
        wait_clks(SETTLE_CLKS);
        check_bit("miso_oe", miso_oe, 1'b0);
        check_regs("reg_q", reg_q, exp_regs[n]);
    endtask

    // ==========================================================
    // Main sequence
    // ==========================================================

    initial begin
        int unsigned seed_val;
        int          n;
        int          err_before;
        int unsigned r_wr;
        int unsigned r_addr;
        int unsigned r_cnt;
        int unsigned r_data;
        clk         = 1'b0;
        rst_n       = 1'b0;
        sck         = 1'b0;
        ss_n        = 1'b1;
        mosi        = 1'b0;
        cycle_cnt   = 0;
        error_count = 0;
        check_count = 0;
        n_txn       = 0;
        seed_val    = $urandom(46);

        // Boundaries, bursts, range edge and aborts
        add_txn(1'b1, 5,   1, 1'b0, 32'h0000003C);
        add_txn(1'b1, 0,   1, 1'b0, 32'h00000081);
        add_txn(1'b1, 15,  1, 1'b0, 32'h0000007E);
        add_txn(1'b1, 4,   4, 1'b0, 32'h44332211);
        add_txn(1'b0, 4,   4, 1'b0, 32'h00000000);
        add_txn(1'b1, 16,  2, 1'b0, 32'h0000EEFF);
        add_txn(1'b1, 127, 4, 1'b0, 32'h96877869);
        add_txn(1'b1, 14,  3, 1'b0, 32'h00D3D2D1);
        add_txn(1'b0, 14,  4, 1'b0, 32'h00000000);
        add_txn(1'b0, 16,  2, 1'b0, 32'h00000000);
        add_txn(1'b1, 10,  1, 1'b1, 32'h000000C3);
        add_txn(1'b1, 9,   2, 1'b1, 32'h00006B5A);
        add_txn(1'b0, 8,   4, 1'b0, 32'h00000000);
        // Random traffic reaching a few addresses past the bank
        while (n_txn < TXN_N - TAIL_N) begin
            r_wr   = $urandom;
            r_addr = $urandom % 20;
            r_cnt  = 1 + $urandom % 4;
            r_data = $urandom;
            add_txn(1'(r_wr), int'(r_addr), int'(r_cnt), 1'b0, r_data);
        end
        // Full read sweep against the model
        for (n = 0; n < TAIL_N; n++) begin
            add_txn(1'b0, n * 4, 4, 1'b0, 32'h00000000);
        end
        build_expected();

        wait_clks(RESET_CYCLES);
        rst_n = 1'b1;
        wait_clks(4);
        err_before = error_count;
        check_regs("reg_q", reg_q, '0);
        check_bit("miso_oe", miso_oe, 1'b0);
        $display("test reset: %s", (error_count == err_before) ? "pass" : "FAIL");

        for (n = 0; n < TXN_N; n++) begin
            err_before = error_count;
            run_txn(n);
            $display("test %0d: %s addr %h bytes %0d%s: %s", n,
                     txns[n].wr ? "write" : "read", txns[n].addr, txns[n].count,
                     txns[n].abort ? " aborted" : "",
                     (error_count == err_before) ? "pass" : "FAIL");
        end

        $display("%0d tests, %0d checks, %0d errors", TXN_N + 1, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
common/spi_reg_pkg.sv
spi_slave/spi_pin_sync.sv
spi_slave/spi_slave_if.sv
hdl/spi_cmd_decoder.sv
hdl/spi_reg_bank.sv
hdl/spi_reg_top.sv
dv/spi_reg_tb.sv

//--- Makefile
TOP := spi_reg_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f all.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
